// ==== src/cpu_mem_interface.sv ====
module cpu_mem_interface (
    input  logic                                  text_mem_clk,
    input  logic                                  reset,
    // CPU side
    input  mem_map_pkg::data_req_t                data_req,
    input  logic [mem_map_pkg::ADDR_W-1:0]        instr_addr,
    output mem_map_pkg::data_word_t               dmem_rdata,
    output mem_map_pkg::data_word_t               instr_rdata,
    output logic                                  mem_stall,
    // cache side, address and data taken from data_req
    output logic                                  ic_read,
    output logic                                  dc_read,
    output logic                                  dc_write,
    input  mem_map_pkg::data_word_t               ic_rdata,
    input  mem_map_pkg::data_word_t               dc_rdata,
    input  logic                                  cache_stall,
    // external loader
    input  logic [mem_map_pkg::LOADER_ADDR_W-1:0] loader_addr,
    output mem_map_pkg::data_word_t               loader_data,
    // display read port
    input  logic [mem_map_pkg::TEXT_ADDR_W-1:0]   text_rd_addr,
    output mem_map_pkg::text_char_t               text_rd_data
);

    // loader ram links
    mem_map_pkg::loader_port_t             loader_port;
    logic [mem_map_pkg::LOADER_ADDR_W-1:0] fetch_addr;
    mem_map_pkg::data_word_t               loader_rdata;
    mem_map_pkg::data_word_t               loader_instr;

    // text path
    logic                  text_sel;
    mem_map_pkg::text_wr_t text_wr;
    mem_map_pkg::text_wr_t text_wr_q;
    logic                  text_we;
    logic                  text_stall;

    logic trap_stall;

    //////////////////////////////////////////////////
    // stage 1, request decode
    //////////////////////////////////////////////////

    request_decode u_request_decode (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .data_req     (data_req),
        .instr_addr   (instr_addr),
        .loader_addr  (loader_addr),
        .loader_rdata (loader_rdata),
        .loader_instr (loader_instr),
        .ic_rdata     (ic_rdata),
        .dc_rdata     (dc_rdata),
        .dmem_rdata   (dmem_rdata),
        .instr_rdata  (instr_rdata),
        .ic_read      (ic_read),
        .dc_read      (dc_read),
        .dc_write     (dc_write),
        .loader_port  (loader_port),
        .fetch_addr   (fetch_addr),
        .text_sel     (text_sel),
        .text_wr      (text_wr),
        .trap_stall   (trap_stall)
    );

    //////////////////////////////////////////////////
    // stage 2, text write sequencer
    //////////////////////////////////////////////////

    text_write_seq u_text_write_seq (
        .text_mem_clk (text_mem_clk),
        .reset        (reset),
        .text_sel     (text_sel),
        .text_wr      (text_wr),
        .wr_en        (text_we),
        .wr_data      (text_wr_q),
        .text_stall   (text_stall)
    );

    //////////////////////////////////////////////////
    // stage 3, memories
    //////////////////////////////////////////////////

    // port a data side, port b instruction fetch
    dual_port_ram #(
        .word_t (mem_map_pkg::data_word_t),
        .DEPTH  (mem_map_pkg::LOADER_DEPTH)
    ) loader_ram (
        .text_mem_clk (text_mem_clk),
        .a_addr       (loader_port.addr),
        .a_wdata      (loader_port.wdata),
        .a_we         (loader_port.we),
        .a_rdata      (loader_rdata),
        .b_addr       (fetch_addr),
        .b_rdata      (loader_instr)
    );

    // port a written by the sequencer, port b feeds the display
    dual_port_ram #(
        .word_t (mem_map_pkg::text_char_t),
        .DEPTH  (mem_map_pkg::TEXT_DEPTH)
    ) text_ram (
        .text_mem_clk (text_mem_clk),
        .a_addr       (text_wr_q.addr),
        .a_wdata      (text_wr_q.chr),
        .a_we         (text_we),
        // write only side, readback goes through port b
        .a_rdata      (),
        .b_addr       (text_rd_addr),
        .b_rdata      (text_rd_data)
    );

    // loader sees whatever port a last read
    assign loader_data = loader_rdata;

    // any source holds the pipeline
    assign mem_stall = cache_stall | text_stall | trap_stall;

endmodule

// ==== src/dual_port_ram.sv ====
module dual_port_ram #(
    parameter type word_t = mem_map_pkg::data_word_t,
    parameter int  DEPTH  = 1024
) (
    input  logic                     text_mem_clk,
    // port a, read and write
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  word_t                    a_wdata,
    input  logic                     a_we,
    output word_t                    a_rdata,
    // port b, read only
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output word_t                    b_rdata
);

    localparam int addr_w = $clog2(DEPTH);

    // block ram array
    word_t mem [DEPTH];

    //////////////////////////////////////////////////
    // port a
    //////////////////////////////////////////////////

    // read first, a write returns the old contents
    always_ff @(posedge text_mem_clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    //////////////////////////////////////////////////
    // port b
    //////////////////////////////////////////////////

    // one cycle latency, same as port a
    always_ff @(posedge text_mem_clk) begin
        b_rdata <= mem[addr_w'(b_addr)];
    end

endmodule

// ==== src/mem_map_pkg.sv ====
package mem_map_pkg;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // word address from the CPU with the byte offset already dropped
    localparam int ADDR_W = 30;

    // region code sits in the top four address bits
    localparam int REGION_W   = 4;
    localparam int REGION_LSB = ADDR_W - REGION_W;

    // region codes on data address bits 29..26
    // anything not listed here goes to the cache
    typedef enum logic [REGION_W-1:0] {
        text_region   = 4'hc,
        timer_region  = 4'hd,
        kbd_region    = 4'he,
        loader_region = 4'hf
    } region_e;

    //////////////////////////////////////////////////
    // memory sizes
    //////////////////////////////////////////////////

    localparam int DATA_W    = 32;
    localparam int CHAR_W    = 8;
    localparam int BYTE_EN_W = DATA_W / CHAR_W;

    // loader ram of 8192 words
    localparam int LOADER_ADDR_W = 13;
    localparam int LOADER_DEPTH  = 1 << LOADER_ADDR_W;

    // text ram holds one character per byte address
    localparam int TEXT_ADDR_W = 15;
    localparam int TEXT_DEPTH  = 1 << TEXT_ADDR_W;

    // sequencer spins here once the write is done
    localparam int TEXT_STALL_LAST = 3;

    //////////////////////////////////////////////////
    // payload types and bundles
    //////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [CHAR_W-1:0] text_char_t;

    // data side request from the pipeline
    // byte_en is one-hot for byte stores and its msb picks byte 0
    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [ADDR_W-1:0]    addr;
        data_word_t           wdata;
        logic [BYTE_EN_W-1:0] byte_en;
    } data_req_t;

    // one character bound for the text ram
    typedef struct packed {
        logic [TEXT_ADDR_W-1:0] addr;
        text_char_t             chr;
    } text_wr_t;

    // loader ram data port shared by CPU and external loader
    typedef struct packed {
        logic [LOADER_ADDR_W-1:0] addr;
        data_word_t               wdata;
        logic                     we;
    } loader_port_t;

endpackage

// ==== src/request_decode.sv ====
module request_decode (
    input  logic                                  text_mem_clk,
    input  logic                                  reset,
    // pipeline side
    input  mem_map_pkg::data_req_t                data_req,
    input  logic [mem_map_pkg::ADDR_W-1:0]        instr_addr,
    // external loader address, used when the CPU is elsewhere
    input  logic [mem_map_pkg::LOADER_ADDR_W-1:0] loader_addr,
    // read data coming back a cycle late
    input  mem_map_pkg::data_word_t               loader_rdata,
    input  mem_map_pkg::data_word_t               loader_instr,
    input  mem_map_pkg::data_word_t               ic_rdata,
    input  mem_map_pkg::data_word_t               dc_rdata,
    output mem_map_pkg::data_word_t               dmem_rdata,
    output mem_map_pkg::data_word_t               instr_rdata,
    // cache strobes
    output logic                                  ic_read,
    output logic                                  dc_read,
    output logic                                  dc_write,
    // loader ram ports
    output mem_map_pkg::loader_port_t             loader_port,
    output logic [mem_map_pkg::LOADER_ADDR_W-1:0] fetch_addr,
    // text write request towards the sequencer
    output logic                                  text_sel,
    output mem_map_pkg::text_wr_t                 text_wr,
    output logic                                  trap_stall
);

    mem_map_pkg::region_e data_region;
    mem_map_pkg::region_e fetch_region;

    logic data_is_text;
    logic data_is_timer;
    logic data_is_kbd;
    logic data_is_loader;
    logic data_is_cache;
    logic fetch_is_loader;

    // region of the previous request, lines up with ram output
    logic data_loader_q;
    logic data_cache_q;
    logic fetch_loader_q;

    logic [1:0] lane;

    //////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////

    assign data_region = mem_map_pkg::region_e'(
        data_req.addr[mem_map_pkg::REGION_LSB +: mem_map_pkg::REGION_W]);
    assign fetch_region = mem_map_pkg::region_e'(
        instr_addr[mem_map_pkg::REGION_LSB +: mem_map_pkg::REGION_W]);

    assign data_is_text   = (data_region == mem_map_pkg::text_region);
    assign data_is_timer  = (data_region == mem_map_pkg::timer_region);
    assign data_is_kbd    = (data_region == mem_map_pkg::kbd_region);
    assign data_is_loader = (data_region == mem_map_pkg::loader_region);
    // low regions all belong to the cache
    assign data_is_cache  = !(data_is_text || data_is_timer || data_is_kbd || data_is_loader);

    assign fetch_is_loader = (fetch_region == mem_map_pkg::loader_region);

    //////////////////////////////////////////////////
    // strobes and stall
    //////////////////////////////////////////////////

    // icache fetches unless the loader ram serves the instruction
    assign ic_read  = !fetch_is_loader;
    assign dc_read  = data_is_cache && data_req.rd;
    assign dc_write = data_is_cache && data_req.wr;

    // timer not modelled, any touch traps the pipeline
    assign trap_stall = data_is_timer && (data_req.rd || data_req.wr);

    // only byte stores reach the text ram
    assign text_sel = data_is_text && data_req.wr;

    // loader port a, CPU wins while it targets region f
    always_comb begin
        loader_port.wdata = data_req.wdata;
        loader_port.we    = data_is_loader && data_req.wr;
        if (data_is_loader) begin
            loader_port.addr = data_req.addr[mem_map_pkg::LOADER_ADDR_W-1:0];
        end else begin
            loader_port.addr = loader_addr;
        end
    end

    // port b, low word bits of the fetch address
    assign fetch_addr = instr_addr[mem_map_pkg::LOADER_ADDR_W-1:0];

    //////////////////////////////////////////////////
    // text lane select
    //////////////////////////////////////////////////

    // one-hot byte_en, msb picks byte 0 of the word
    always_comb begin
        case (data_req.byte_en)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            4'b0001: lane = 2'd3;
            // not one-hot, fall back to lane 3
            default: lane = 2'd3;
        endcase
    end

    // byte address is word address plus lane
    assign text_wr.addr = {data_req.addr[mem_map_pkg::TEXT_ADDR_W-3:0], lane};
    assign text_wr.chr  = data_req.wdata[lane*mem_map_pkg::CHAR_W +: mem_map_pkg::CHAR_W];

    //////////////////////////////////////////////////
    // read data steering
    //////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (reset) begin
            data_loader_q  <= 1'b0;
            data_cache_q   <= 1'b0;
            fetch_loader_q <= 1'b0;
        end else begin
            data_loader_q  <= data_is_loader;
            data_cache_q   <= data_is_cache;
            fetch_loader_q <= fetch_is_loader;
        end
    end

    // keyboard, timer and text reads return zero
    always_comb begin
        if (data_loader_q) begin
            dmem_rdata = loader_rdata;
        end else if (data_cache_q) begin
            dmem_rdata = dc_rdata;
        end else begin
            dmem_rdata = '0;
        end
    end

    assign instr_rdata = fetch_loader_q ? loader_instr : ic_rdata;

endmodule

// ==== src/text_write_seq.sv ====
module text_write_seq (
    input  logic                  text_mem_clk,
    input  logic                  reset,
    // level from decode, held by the CPU while stalled
    input  logic                  text_sel,
    input  mem_map_pkg::text_wr_t text_wr,
    // text ram write port
    output logic                  wr_en,
    output mem_map_pkg::text_wr_t wr_data,
    output logic                  text_stall
);

    localparam int cnt_w = $clog2(mem_map_pkg::TEXT_STALL_LAST + 1);

    // 0 idle, 1 and 2 writing, last spins until text_sel drops
    logic [cnt_w-1:0] count;

    //////////////////////////////////////////////////
    // counter and write enable
    //////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (reset || !text_sel) begin
            count <= '0;
            wr_en <= 1'b0;
        end else if (count >= cnt_w'(mem_map_pkg::TEXT_STALL_LAST - 1)) begin
            // write done, hold here so the pipeline can move on
            count <= cnt_w'(mem_map_pkg::TEXT_STALL_LAST);
            wr_en <= 1'b0;
        end else begin
            count <= count + 1'b1;
            wr_en <= 1'b1;
        end
    end

    // capture address and char on entry so the ram sees stable values
    always_ff @(posedge text_mem_clk) begin
        if (text_sel && (count == '0)) begin
            wr_data <= text_wr;
        end
    end

    //////////////////////////////////////////////////
    // stall
    //////////////////////////////////////////////////

    // combinational, rises with the request in cycle 0
    // falls once the count reaches its spin value
    assign text_stall = text_sel && (count != cnt_w'(mem_map_pkg::TEXT_STALL_LAST));

endmodule

// ==== tb.f ====
src/mem_map_pkg.sv
src/dual_port_ram.sv
src/request_decode.sv
src/text_write_seq.sv
src/cpu_mem_interface.sv
verif/cpu_mem_interface_sva.sv
verif/tb_cpu_mem_interface.sv

// ==== verif/cpu_mem_interface_sva.sv ====
module cpu_mem_interface_sva (
    input logic       text_mem_clk,
    input logic       reset,
    input logic       text_sel,
    input logic       wr_en,
    input logic       text_stall,
    input logic [1:0] count
);

    //////////////////////////////////////////////////
    // write sequencer timing
    //////////////////////////////////////////////////

    // write pulse two cycles at most
    write_burst_max: assert property (@(posedge text_mem_clk) disable iff (reset)
        wr_en ##1 wr_en |=> !wr_en)
        else $error("text write enable high for more than two cycles");

    // spinning at the last count releases the pipeline
    stall_clear_at_last: assert property (@(posedge text_mem_clk) disable iff (reset)
        (count == 2'(mem_map_pkg::TEXT_STALL_LAST)) |-> !text_stall)
        else $error("text_stall high while count is at its last value");

    // a held request stalls for exactly three cycles
    stall_three_cycles: assert property (@(posedge text_mem_clk) disable iff (reset)
        $rose(text_stall) |-> text_stall [*3] ##1 !text_stall)
        else $error("text_stall not high for exactly three cycles");

    // reset clears the counter and write enable
    reset_clears: assert property (@(posedge text_mem_clk)
        reset |=> (!wr_en && count == 2'd0))
        else $error("write enable or count not cleared by reset");

endmodule

bind text_write_seq cpu_mem_interface_sva sva_u (
    .text_mem_clk (text_mem_clk),
    .reset        (reset),
    .text_sel     (text_sel),
    .wr_en        (wr_en),
    .text_stall   (text_stall),
    .count        (count)
);

// ==== verif/mem_patterns.txt ====
# op addr wdata byte_en cdata expected, all hex
# op: 1 text write, 2 loader, 3 timer, 4 keyboard, 5 cache read, 6 cache write, 7 fetch
1 30000010 44434241 8 0 41
1 30000010 44434241 4 0 42
1 30000010 44434241 2 0 43
1 30000010 44434241 1 0 44
1 30000233 7e5a5a5a 3 0 7e
2 3c000005 deadbeef 0 0 deadbeef
2 3c001fff 01234567 0 0 01234567
3 34000000 0 0 0 1
3 34000040 0 f 0 1
4 38000000 0 0 0 0
5 00001234 0 0 cafef00d cafef00d
5 0abcdef0 0 0 12345678 12345678
6 00000100 aa55aa55 f 0 0
7 00000800 0 0 87654321 87654321
7 2ffffff0 0 0 0badf00d 0badf00d

// ==== verif/tb_cpu_mem_interface.sv ====
module tb_cpu_mem_interface;

    localparam int STALL_LIMIT = 64;

    logic                                  text_mem_clk;
    logic                                  reset;
    mem_map_pkg::data_req_t                data_req;
    logic [mem_map_pkg::ADDR_W-1:0]        instr_addr;
    mem_map_pkg::data_word_t               dmem_rdata;
    mem_map_pkg::data_word_t               instr_rdata;
    logic                                  mem_stall;
    logic                                  ic_read;
    logic                                  dc_read;
    logic                                  dc_write;
    mem_map_pkg::data_word_t               ic_rdata;
    mem_map_pkg::data_word_t               dc_rdata;
    logic                                  cache_stall;
    logic [mem_map_pkg::LOADER_ADDR_W-1:0] loader_addr;
    mem_map_pkg::data_word_t               loader_data;
    logic [mem_map_pkg::TEXT_ADDR_W-1:0]   text_rd_addr;
    mem_map_pkg::text_char_t               text_rd_data;

    // galois lfsr state for cache stall and filler data
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    cpu_mem_interface uut (.*);

    initial begin
        text_mem_clk = 1'b0;
        forever #5 text_mem_clk = ~text_mem_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic mem_map_pkg::data_req_t make_req(input logic rd, input logic wr,
        input logic [29:0] addr, input logic [31:0] wdata, input logic [3:0] be);
        mem_map_pkg::data_req_t req;
        req.rd      = rd;
        req.wr      = wr;
        req.addr    = addr;
        req.wdata   = wdata;
        req.byte_en = be;
        return req;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
        input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout at %0t: %s", $time, what);
        finish_run;
    endtask

    // bus quiet, cache data lines carry noise
    task automatic drive_idle;
        @(posedge text_mem_clk);
        data_req    <= '0;
        instr_addr  <= '0;
        cache_stall <= 1'b0;
        ic_rdata    <= rand_bits(32);
        dc_rdata    <= rand_bits(32);
    endtask

    // counts stalled cycles, sampled mid cycle
    task automatic wait_stall_low(output int cycles);
        cycles = 0;
        @(negedge text_mem_clk);
        while (mem_stall) begin
            cycles++;
            if (cycles > STALL_LIMIT) begin
                stop_on_timeout("mem_stall never dropped");
            end
            @(negedge text_mem_clk);
        end
    endtask

    //////////////////////////////////////////////////
    // access sequences
    //////////////////////////////////////////////////

    task automatic text_write(input logic [29:0] addr, input logic [31:0] wdata,
        input logic [3:0] be, input logic [31:0] exp);
        logic [1:0] lane;
        int         cycles;
        // one-hot, msb is byte 0, anything else is lane 3
        case (be)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            default: lane = 2'd3;
        endcase
        @(posedge text_mem_clk);
        data_req <= make_req(1'b0, 1'b1, addr, wdata, be);
        wait_stall_low(cycles);
        check_value("text stall cycles", cycles, 3);
        @(posedge text_mem_clk);
        data_req     <= '0;
        text_rd_addr <= {addr[12:0], lane};
        // display port has one cycle of latency
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        check_value("text display byte", text_rd_data, exp);
    endtask

    task automatic loader_access(input logic [29:0] addr, input logic [31:0] wdata,
        input logic [31:0] exp);
        @(posedge text_mem_clk);
        data_req <= make_req(1'b0, 1'b1, addr, wdata, 4'h0);
        @(negedge text_mem_clk);
        check_value("loader write stall", mem_stall, 0);
        @(posedge text_mem_clk);
        data_req <= make_req(1'b1, 1'b0, addr, '0, 4'h0);
        // read data lands the cycle after the address
        @(posedge text_mem_clk);
        data_req    <= '0;
        loader_addr <= addr[12:0];
        instr_addr  <= addr;
        @(negedge text_mem_clk);
        check_value("loader dmem_rdata", dmem_rdata, exp);
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        check_value("loader_data", loader_data, exp);
        check_value("loader fetch", instr_rdata, exp);
        check_value("ic_read on loader fetch", ic_read, 0);
    endtask

    task automatic timer_access(input logic [29:0] addr, input logic [3:0] be,
        input logic [31:0] exp);
        @(posedge text_mem_clk);
        data_req <= make_req(be == 4'h0, be != 4'h0, addr, '0, be);
        // held request keeps the trap up
        repeat (4) begin
            @(negedge text_mem_clk);
            check_value("timer stall", mem_stall, exp);
        end
        @(posedge text_mem_clk);
        data_req <= '0;
        @(negedge text_mem_clk);
        check_value("timer release", mem_stall, 0);
    endtask

    task automatic kbd_read(input logic [29:0] addr, input logic [31:0] exp);
        @(posedge text_mem_clk);
        data_req <= make_req(1'b1, 1'b0, addr, '0, 4'h0);
        @(negedge text_mem_clk);
        check_value("kbd stall", mem_stall, 0);
        @(posedge text_mem_clk);
        data_req <= '0;
        @(negedge text_mem_clk);
        check_value("kbd rdata", dmem_rdata, exp);
    endtask

    task automatic cache_access(input logic wr, input logic [29:0] addr,
        input logic [31:0] wdata, input logic [3:0] be, input logic [31:0] cdata,
        input logic [31:0] exp);
        int cycles;
        cycles = 0;
        @(posedge text_mem_clk);
        data_req    <= make_req(!wr, wr, addr, wdata, be);
        dc_rdata    <= cdata;
        cache_stall <= rand_bits(1);
        @(negedge text_mem_clk);
        check_value("dc_read", dc_read, !wr);
        check_value("dc_write", dc_write, wr);
        check_value("cache stall", mem_stall, cache_stall);
        // request held while the cache stalls
        while (mem_stall) begin
            cycles++;
            if (cycles > STALL_LIMIT) begin
                stop_on_timeout("cache stall never dropped");
            end
            @(posedge text_mem_clk);
            cache_stall <= rand_bits(1);
            @(negedge text_mem_clk);
            check_value("cache stall", mem_stall, cache_stall);
        end
        @(posedge text_mem_clk);
        data_req <= '0;
        @(negedge text_mem_clk);
        if (!wr) begin
            check_value("dc rdata", dmem_rdata, exp);
        end
    endtask

    task automatic cache_fetch(input logic [29:0] addr, input logic [31:0] cdata,
        input logic [31:0] exp);
        @(posedge text_mem_clk);
        instr_addr <= addr;
        ic_rdata   <= cdata;
        @(negedge text_mem_clk);
        check_value("ic_read", ic_read, 1);
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        check_value("ic instr_rdata", instr_rdata, exp);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        string       line;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] be;
        logic [31:0] cdata;
        logic [31:0] exp;
        lfsr         = 16'd37;
        checks       = 0;
        errors       = 0;
        reset        = 1'b1;
        data_req     = '0;
        instr_addr   = '0;
        ic_rdata     = '0;
        dc_rdata     = '0;
        cache_stall  = 1'b0;
        loader_addr  = '0;
        text_rd_addr = '0;
        repeat (16) @(posedge text_mem_clk);
        reset <= 1'b0;
        // out of reset, cache fetch is the default
        @(negedge text_mem_clk);
        check_value("reset ic_read", ic_read, 1);
        check_value("reset dc_read", dc_read, 0);
        check_value("reset dc_write", dc_write, 0);
        check_value("reset mem_stall", mem_stall, 0);
        fd = $fopen("verif/mem_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/mem_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                // comment and blank lines do not scan
                if ($sscanf(line, "%h %h %h %h %h %h", op, addr, wdata, be, cdata, exp) != 6) begin
                    continue;
                end
                case (op)
                    1: text_write(addr[29:0], wdata, be[3:0], exp);
                    2: loader_access(addr[29:0], wdata, exp);
                    3: timer_access(addr[29:0], be[3:0], exp);
                    4: kbd_read(addr[29:0], exp);
                    5: cache_access(1'b0, addr[29:0], wdata, be[3:0], cdata, exp);
                    6: cache_access(1'b1, addr[29:0], wdata, be[3:0], cdata, exp);
                    7: cache_fetch(addr[29:0], cdata, exp);
                    default: begin
                        errors++;
                        $display("unknown operation %0h in pattern file", op);
                    end
                endcase
                drive_idle;
            end
            $fclose(fd);
        end
        finish_run;
    end

endmodule
